// File: flist.f
+incdir+verification
source/cop_pkg.sv
source/cop_palu_adder.sv
source/cop_palu_shifter.sv
source/cop_issue.sv
source/cop_palu.sv
source/cop_writeback.sv
source/cop_top.sv
verification/cop_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module cop_tb -o cop_sim

./obj_dir/cop_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

// File: source/cop_issue.sv
`timescale 1ns/100ps

module cop_issue (
    input  logic               g_clk,
    input  logic               arst_n,
    input  logic               issue_valid,
    input  cop_pkg::cop_insn_t issue,
    output logic               op_valid,
    output cop_pkg::cop_op_t   op
);
    import cop_pkg::*;

    logic       c_mov, c_bw, c_pa, c_tw;   // Class hits
    logic [3:0] sc;
    cop_op_t    dec_op;

    assign c_mov = issue.iclass == cop_iclass_move;
    assign c_bw  = issue.iclass == cop_iclass_bitwise;
    assign c_pa  = issue.iclass == cop_iclass_parith;
    assign c_tw  = issue.iclass == cop_iclass_twiddle;
    assign sc    = issue.subclass;

    // Unknown class or subclass leaves sel all zero
    always_comb begin
        dec_op             = '0;
        dec_op.sel.cmov    = c_mov && sc == cop_sclass_cmov;
        dec_op.sel.cmovn   = c_mov && sc == cop_sclass_cmovn;
        dec_op.sel.mv2cop  = c_mov && sc == cop_sclass_mv2cop;
        dec_op.sel.lmix    = c_bw  && sc == cop_sclass_lmix;
        dec_op.sel.hmix    = c_bw  && sc == cop_sclass_hmix;
        dec_op.sel.bop     = c_bw  && sc == cop_sclass_bop;
        dec_op.sel.ins     = c_bw  && sc == cop_sclass_ins;
        dec_op.sel.ext     = c_bw  && sc == cop_sclass_ext;
        dec_op.sel.lli     = c_bw  && sc == cop_sclass_lli;
        dec_op.sel.lui     = c_bw  && sc == cop_sclass_lui;
        dec_op.sel.twid_b  = c_tw  && sc == cop_sclass_twid_b;
        dec_op.sel.twid_n0 = c_tw  && sc == cop_sclass_twid_n0;
        dec_op.sel.twid_n1 = c_tw  && sc == cop_sclass_twid_n1;
        dec_op.sel.twid_c0 = c_tw  && sc == cop_sclass_twid_c0;
        dec_op.sel.twid_c1 = c_tw  && sc == cop_sclass_twid_c1;
        dec_op.sel.twid_c2 = c_tw  && sc == cop_sclass_twid_c2;
        dec_op.sel.twid_c3 = c_tw  && sc == cop_sclass_twid_c3;
        dec_op.sel.add     = c_pa  && sc == cop_sclass_add;
        dec_op.sel.sub     = c_pa  && sc == cop_sclass_sub;
        dec_op.sel.sll     = c_pa  && sc == cop_sclass_sll;
        dec_op.sel.srl     = c_pa  && sc == cop_sclass_srl;
        dec_op.sel.rot     = c_pa  && sc == cop_sclass_rot;
        dec_op.sel.slli    = c_pa  && sc == cop_sclass_slli;
        dec_op.sel.srli    = c_pa  && sc == cop_sclass_srli;
        dec_op.sel.roti    = c_pa  && sc == cop_sclass_roti;
        dec_op.pw          = issue.pw;
        dec_op.imm         = issue.imm;
        dec_op.gpr_rs1     = issue.gpr_rs1;
        dec_op.rd          = issue.rd;
        dec_op.rs1         = issue.rs1;
        dec_op.rs2         = issue.rs2;
        dec_op.rs3         = issue.rs3;
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            op_valid <= 1'b0;
            op       <= '0;
        end else begin
            op_valid <= issue_valid;          // Valid for one cycle after capture
            if (issue_valid) op <= dec_op;    // Held between strobes
        end
    end

    a_op_onehot: assert property (@(posedge g_clk) disable iff (!arst_n)
        op_valid |-> $onehot0(op.sel))
        else $error("cop_issue: more than one operation selected");

endmodule

// File: source/cop_palu.sv
`timescale 1ns/100ps

module cop_palu (
    input  logic                 op_valid,
    input  cop_pkg::cop_op_t     op,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  logic [31:0]          rs3_data,   // Old rd value for INS, MIX, LLI, LUI
    output cop_pkg::cop_result_t wb
);
    import cop_pkg::*;

    cop_opsel_t s;
    logic       is_mov, is_bw, is_twid, is_pa;
    assign s = op.sel;

    // --------------------------------------------------
    // Moves
    logic        mov_cond, mov_wen;
    logic [31:0] mov_res;

    assign mov_cond = rs2_data == '0;
    assign mov_wen  = s.mv2cop | (s.cmov & mov_cond) | (s.cmovn & ~mov_cond);
    assign mov_res  = s.mv2cop ? op.gpr_rs1 : rs1_data;

    // --------------------------------------------------
    // Bitwise
    logic [4:0]  ei_start, ei_len, mix_ramt;
    logic [31:0] ei_mask, ins_field, ext_res, ins_res, mix_res, bop_res, bw_res;
    logic [63:0] mix_dbl;

    assign ei_start  = {op.imm[7:4], 1'b0};              // Doubled nibbles
    assign ei_len    = {op.imm[3:0], 1'b0};
    assign ei_mask   = ~(32'hffff_ffff << ei_len);       // len ones at bottom
    assign ins_field = ei_mask << ei_start;
    assign ext_res   = (rs1_data >> ei_start) & ei_mask;
    assign ins_res   = ((rs1_data << ei_start) & ins_field) | (rs3_data & ~ins_field);

    assign mix_ramt  = {s.hmix, op.imm[3:0]};            // HMIX adds 16
    assign mix_dbl   = {rs1_data, rs1_data} >> mix_ramt; // Rotate right
    assign mix_res   = (rs2_data & mix_dbl[31:0]) | (~rs2_data & rs3_data);

    // BOP truth table lookup per bit
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            bop_res[i] = op.imm[{rs1_data[i], rs2_data[i]}];
        end
    end

    assign bw_res = {32{s.bop}}           & bop_res                         |
                    {32{s.ext}}           & ext_res                         |
                    {32{s.ins}}           & ins_res                         |
                    {32{s.lmix | s.hmix}} & mix_res                         |
                    {32{s.lli}}           & {rs3_data[31:16], op.imm[15:0]} |
                    {32{s.lui}}           & {op.imm[15:0], rs3_data[15:0]};

    // --------------------------------------------------
    // Twiddle
    logic        tw_crumb;
    logic [1:0]  tw_cidx;     // Byte holding the crumbs
    logic [15:0] tw_half, tw_n;
    logic [7:0]  tw_byte, tw_c;
    logic [31:0] tw_b, twid_res;

    assign tw_crumb = s.twid_c0 | s.twid_c1 | s.twid_c2 | s.twid_c3;
    assign tw_cidx  = {s.twid_c3 | s.twid_c2, s.twid_c3 | s.twid_c1};
    assign tw_half  = s.twid_n1 ? rs1_data[31:16] : rs1_data[15:0];
    assign tw_byte  = rs1_data[8*tw_cidx +: 8];

    always_comb begin
        logic [1:0] src;
        for (int k = 0; k < 4; k++) begin
            src            = op.imm[7-2*k -: 2];  // Lane 0 picked by imm[7:6]
            tw_b[8*k +: 8] = rs1_data[8*src +: 8];
            tw_n[4*k +: 4] = tw_half[4*src +: 4];
            tw_c[2*k +: 2] = tw_byte[2*src +: 2];
        end
        twid_res = rs1_data;                      // Unselected parts pass
        if (s.twid_b) twid_res = tw_b;
        if (s.twid_n0) twid_res[15:0] = tw_n;
        if (s.twid_n1) twid_res[31:16] = tw_n;
        if (tw_crumb) twid_res[8*tw_cidx +: 8] = tw_c;
    end

    // --------------------------------------------------
    // Packed arithmetic
    logic        pa_shift, pa_imm, pa_left, pa_rot;
    logic [2:0]  pa_pw;
    logic [4:0]  pa_shamt;
    logic [31:0] add_res, shf_res, pa_res;

    assign pa_shift = s.sll | s.srl | s.rot | s.slli | s.srli | s.roti;
    assign pa_imm   = s.slli | s.srli | s.roti;
    assign pa_left  = s.sll | s.slli;
    assign pa_rot   = s.rot | s.roti;
    assign pa_pw    = (s.add | s.sub | pa_shift) ? op.pw : cop_pw_32;  // pw only meaningful here
    assign pa_shamt = pa_imm ? op.imm[4:0] : rs2_data[4:0];
    assign pa_res   = pa_shift ? shf_res : add_res;

    cop_palu_adder i_palu_adder (
        .a   (rs1_data),
        .b   (rs2_data),
        .pw  (pa_pw),
        .sub (s.sub),
        .c   (add_res)
    );

    cop_palu_shifter i_palu_shifter (
        .a      (rs1_data),
        .shamt  (pa_shamt),
        .pw     (pa_pw),
        .left   (pa_left),
        .rotate (pa_rot),
        .c      (shf_res)
    );

    // --------------------------------------------------
    // Result merge, sel is one-hot
    assign is_mov  = op_valid & (s.cmov | s.cmovn | s.mv2cop);
    assign is_bw   = op_valid & (s.lmix | s.hmix | s.bop | s.ins | s.ext | s.lli | s.lui);
    assign is_twid = op_valid & (s.twid_b | s.twid_n0 | s.twid_n1 | tw_crumb);
    assign is_pa   = op_valid & (s.add | s.sub | pa_shift);

    assign wb.rd   = op.rd;
    assign wb.ben  = is_mov                    ? {4{mov_wen}} :
                     (is_bw | is_twid | is_pa) ? 4'hf         : 4'h0;
    assign wb.data = {32{is_mov}}  & mov_res  |
                     {32{is_bw}}   & bw_res   |
                     {32{is_twid}} & twid_res |
                     {32{is_pa}}   & pa_res;

endmodule

// File: source/cop_palu_adder.sv
`timescale 1ns/100ps

module cop_palu_adder (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  pw,
    input  logic        sub,    // a - b via ~b and carry in
    output logic [31:0] c
);
    import cop_pkg::*;

    logic [31:0] lane_lsb;      // Set where a lane starts
    logic [31:0] b_eff;

    always_comb begin
        case (pw)
            cop_pw_16: lane_lsb = 32'h0001_0001;
            cop_pw_8:  lane_lsb = 32'h0101_0101;
            cop_pw_4:  lane_lsb = 32'h1111_1111;
            cop_pw_2:  lane_lsb = 32'h5555_5555;
            default:   lane_lsb = 32'h0000_0001;   // Single 32-bit lane
        endcase
    end

    assign b_eff = b ^ {32{sub}};

    // Ripple chain, restarted at each lane bottom
    always_comb begin
        logic cy;
        cy = sub;
        for (int i = 0; i < 32; i++) begin
            if (lane_lsb[i]) cy = sub;              // Drop carry from lane below
            c[i] = a[i] ^ b_eff[i] ^ cy;
            cy   = (a[i] & b_eff[i]) | (cy & (a[i] ^ b_eff[i]));
        end
    end

    always_comb begin
        if (!$isunknown(pw)) begin
            assert (pw <= cop_pw_2) else $error("cop_palu_adder: illegal pack width %0d", pw);
        end
    end

endmodule

// File: source/cop_palu_shifter.sv
`timescale 1ns/100ps

module cop_palu_shifter (
    input  logic [31:0] a,
    input  logic [4:0]  shamt,
    input  logic [2:0]  pw,
    input  logic        left,     // Shift left, else right
    input  logic        rotate,   // Rotate right
    output logic [31:0] c
);
    import cop_pkg::*;

    logic [4:0] lmask;            // Lane width minus one
    logic [4:0] amt;

    always_comb begin
        case (pw)
            cop_pw_16: lmask = 5'd15;
            cop_pw_8:  lmask = 5'd7;
            cop_pw_4:  lmask = 5'd3;
            cop_pw_2:  lmask = 5'd1;
            default:   lmask = 5'd31;
        endcase
    end

    assign amt = shamt & lmask;   // Amount modulo lane width

    // Each output bit picks its source inside its own lane
    always_comb begin
        logic [5:0] pos, src;
        logic       keep;
        for (int i = 0; i < 32; i++) begin
            pos = 6'(i) & {1'b0, lmask};         // Bit position within lane
            if (left && !rotate) begin
                keep = pos >= {1'b0, amt};       // Zero fill from the bottom
                src  = pos - {1'b0, amt};
            end else begin
                src  = pos + {1'b0, amt};
                keep = rotate | (src <= {1'b0, lmask});
            end
            src  = src & {1'b0, lmask};          // Wrap for rotate
            c[i] = keep & a[i - pos + src];
        end
    end

endmodule

// File: source/cop_pkg.sv
package cop_pkg;

    // Datapath and register file sizing
    localparam int cop_xlen  = 32;
    localparam int cop_nregs = 16;
    localparam int cop_regw  = 4;     // Index into cop_nregs

    // --------------------------------------------------
    // Instruction classes
    localparam logic [2:0] cop_iclass_move    = 3'd1;
    localparam logic [2:0] cop_iclass_bitwise = 3'd2;
    localparam logic [2:0] cop_iclass_parith  = 3'd3;
    localparam logic [2:0] cop_iclass_twiddle = 3'd4;

    // Move class subclasses
    localparam logic [3:0] cop_sclass_cmov    = 4'd0;
    localparam logic [3:0] cop_sclass_cmovn   = 4'd1;
    localparam logic [3:0] cop_sclass_mv2cop  = 4'd2;

    // Bitwise class subclasses
    localparam logic [3:0] cop_sclass_lmix    = 4'd0;
    localparam logic [3:0] cop_sclass_hmix    = 4'd1;
    localparam logic [3:0] cop_sclass_bop     = 4'd2;
    localparam logic [3:0] cop_sclass_ins     = 4'd3;
    localparam logic [3:0] cop_sclass_ext     = 4'd4;
    localparam logic [3:0] cop_sclass_lli     = 4'd5;
    localparam logic [3:0] cop_sclass_lui     = 4'd6;

    // Twiddle class subclasses
    localparam logic [3:0] cop_sclass_twid_b  = 4'd0;
    localparam logic [3:0] cop_sclass_twid_n0 = 4'd1;
    localparam logic [3:0] cop_sclass_twid_n1 = 4'd2;
    localparam logic [3:0] cop_sclass_twid_c0 = 4'd3;
    localparam logic [3:0] cop_sclass_twid_c1 = 4'd4;
    localparam logic [3:0] cop_sclass_twid_c2 = 4'd5;
    localparam logic [3:0] cop_sclass_twid_c3 = 4'd6;

    // Packed arithmetic subclasses, no multiply
    localparam logic [3:0] cop_sclass_add     = 4'd0;
    localparam logic [3:0] cop_sclass_sub     = 4'd1;
    localparam logic [3:0] cop_sclass_sll     = 4'd2;
    localparam logic [3:0] cop_sclass_srl     = 4'd3;
    localparam logic [3:0] cop_sclass_rot     = 4'd4;
    localparam logic [3:0] cop_sclass_slli    = 4'd5;
    localparam logic [3:0] cop_sclass_srli    = 4'd6;
    localparam logic [3:0] cop_sclass_roti    = 4'd7;

    // Pack widths, lane width is 32 >> pw
    localparam logic [2:0] cop_pw_32 = 3'd0;
    localparam logic [2:0] cop_pw_16 = 3'd1;
    localparam logic [2:0] cop_pw_8  = 3'd2;
    localparam logic [2:0] cop_pw_4  = 3'd3;
    localparam logic [2:0] cop_pw_2  = 3'd4;

    // --------------------------------------------------
    typedef struct packed {
        logic [2:0]          iclass;
        logic [3:0]          subclass;
        logic [2:0]          pw;
        logic [cop_regw-1:0] rd, rs1, rs2, rs3;
        logic [cop_xlen-1:0] imm;
        logic [cop_xlen-1:0] gpr_rs1;   // Host GPR operand
    } cop_insn_t;

    // One bit per operation, at most one set
    typedef struct packed {
        logic cmov, cmovn, mv2cop;
        logic lmix, hmix, bop, ins, ext, lli, lui;
        logic twid_b, twid_n0, twid_n1, twid_c0, twid_c1, twid_c2, twid_c3;
        logic add, sub, sll, srl, rot, slli, srli, roti;
    } cop_opsel_t;

    typedef struct packed {
        cop_opsel_t          sel;
        logic [2:0]          pw;
        logic [cop_xlen-1:0] imm;
        logic [cop_xlen-1:0] gpr_rs1;
        logic [cop_regw-1:0] rd, rs1, rs2, rs3;
    } cop_op_t;

    typedef struct packed {
        logic [cop_regw-1:0]   rd;
        logic [cop_xlen/8-1:0] ben;    // Byte write enables
        logic [cop_xlen-1:0]   data;
    } cop_result_t;

endpackage

// File: source/cop_top.sv
`timescale 1ns/100ps

module cop_top (
    input  logic                 g_clk,
    input  logic                 arst_n,
    input  logic                 issue_valid,
    input  cop_pkg::cop_insn_t   issue,
    output logic                 result_valid,
    output cop_pkg::cop_result_t result
);
    import cop_pkg::*;

    logic                op_valid;
    cop_op_t             op;
    cop_result_t         wb;                           // PALU to register file
    logic [cop_xlen-1:0] rs1_data, rs2_data, rs3_data;

    cop_issue i_issue (
        .g_clk       (g_clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .op_valid    (op_valid),
        .op          (op)
    );

    cop_palu i_palu (
        .op_valid (op_valid),
        .op       (op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs3_data (rs3_data),
        .wb       (wb)
    );

    cop_writeback i_writeback (
        .g_clk        (g_clk),
        .arst_n       (arst_n),
        .op           (op),
        .wb           (wb),
        .op_valid     (op_valid),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs3_data     (rs3_data),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: source/cop_writeback.sv
`timescale 1ns/100ps

module cop_writeback (
    input  logic                          g_clk,
    input  logic                          arst_n,
    input  cop_pkg::cop_op_t              op,        // Read indices only
    input  cop_pkg::cop_result_t          wb,
    input  logic                          op_valid,
    output logic [cop_pkg::cop_xlen-1:0]  rs1_data,
    output logic [cop_pkg::cop_xlen-1:0]  rs2_data,
    output logic [cop_pkg::cop_xlen-1:0]  rs3_data,
    output logic                          result_valid,
    output cop_pkg::cop_result_t          result
);
    import cop_pkg::*;

    logic [cop_xlen-1:0] regs [cop_nregs];

    // --------------------------------------------------
    // Register file, byte-enabled write
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < cop_nregs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < cop_xlen/8; b++) begin
                if (wb.ben[b]) regs[wb.rd][8*b +: 8] <= wb.data[8*b +: 8];
            end
        end
    end

    // Combinational reads, write lands before next op
    assign rs1_data = regs[op.rs1];
    assign rs2_data = regs[op.rs2];
    assign rs3_data = regs[op.rs3];   // rd slot for read-modify ops

    // --------------------------------------------------
    // Result strobe, same edge as the commit
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= op_valid;
            if (op_valid) result <= wb;   // Last result held otherwise
        end
    end

    // No write may come from an idle PALU
    a_ben_idle: assert property (@(posedge g_clk) disable iff (!arst_n)
        !op_valid |-> wb.ben == '0)
        else $error("cop_writeback: byte enables set with no valid op");

endmodule

// File: verification/cop_ref_model.svh
`ifndef COP_REF_MODEL_SVH
`define COP_REF_MODEL_SVH

// Shadow copy of the coprocessor register file
logic [31:0] ref_regs [16];

// --------------------------------------------------
// Per-lane add, subtract, shift and rotate
function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                           input int amt_in, input int w, input logic [3:0] sc);
    logic [31:0] res, m, x, y, r;
    int          amt;
    res = '0;
    m   = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
    amt = amt_in % w;                     // Amount wraps at lane width
    for (int l = 0; l < 32 / w; l++) begin
        x = (a >> (l * w)) & m;
        y = (b >> (l * w)) & m;
        case (sc)
            cop_sclass_add:                  r = x + y;
            cop_sclass_sub:                  r = x - y;
            cop_sclass_sll, cop_sclass_slli: r = x << amt;
            cop_sclass_srl, cop_sclass_srli: r = x >> amt;
            default:                         r = (amt == 0) ? x : (x >> amt) | (x << (w - amt));
        endcase
        res = res | ((r & m) << (l * w));  // Lane result, upper bits dropped
    end
    return res;
endfunction

// Lane k of the selected field takes source lane sel[7-2k:6-2k]
function automatic logic [31:0] twiddle_ref(input logic [31:0] a, input logic [7:0] sel,
                                            input logic [3:0] sc);
    logic [31:0] r;
    int          base, lw, s;
    r = a;
    case (sc)
        cop_sclass_twid_b:  begin base = 0;  lw = 8; end
        cop_sclass_twid_n0: begin base = 0;  lw = 4; end
        cop_sclass_twid_n1: begin base = 16; lw = 4; end
        default:            begin base = 8 * (int'(sc) - 3); lw = 2; end   // Crumbs of a byte
    endcase
    for (int k = 0; k < 4; k++) begin
        s = (sel >> (6 - 2 * k)) & 3;
        for (int j = 0; j < lw; j++) r[base + lw * k + j] = a[base + lw * s + j];
    end
    return r;
endfunction

// --------------------------------------------------
// Expected result of one instruction against the shadow registers
function automatic cop_result_t model_exec(input cop_insn_t insn);
    cop_result_t r;
    logic [31:0] a, b, c, x;
    int          st, ln, amt;
    a      = ref_regs[insn.rs1];
    b      = ref_regs[insn.rs2];
    c      = ref_regs[insn.rs3];
    x      = '0;
    r.rd   = insn.rd;
    r.ben  = 4'hf;
    st     = 2 * int'(insn.imm[7:4]);
    ln     = 2 * int'(insn.imm[3:0]);
    case (insn.iclass)
        cop_iclass_move: begin
            x = (insn.subclass == cop_sclass_mv2cop) ? insn.gpr_rs1 : a;
            if ((insn.subclass == cop_sclass_cmov && b != 0) ||
                (insn.subclass == cop_sclass_cmovn && b == 0)) r.ben = 4'h0;
        end
        cop_iclass_bitwise: begin
            for (int i = 0; i < 32; i++) begin
                case (insn.subclass)
                    cop_sclass_bop: x[i] = insn.imm[2 * a[i] + b[i]];
                    cop_sclass_ext: if (i < ln && i + st < 32) x[i] = a[i + st];
                    cop_sclass_ins: x[i] = (i >= st && i < st + ln) ? a[i - st] : c[i];
                    default:        x[i] = 1'b0;
                endcase
            end
            if (insn.subclass == cop_sclass_lmix || insn.subclass == cop_sclass_hmix) begin
                amt = int'(insn.imm[3:0]) + ((insn.subclass == cop_sclass_hmix) ? 16 : 0);
                x   = lane_arith(a, 32'd0, amt, 32, cop_sclass_rot);
                x   = (x & b) | (c & ~b);
            end
            if (insn.subclass == cop_sclass_lli) x = {c[31:16], insn.imm[15:0]};
            if (insn.subclass == cop_sclass_lui) x = {insn.imm[15:0], c[15:0]};
        end
        cop_iclass_twiddle: x = twiddle_ref(a, insn.imm[7:0], insn.subclass);
        cop_iclass_parith: begin
            amt = (insn.subclass >= cop_sclass_slli) ? int'(insn.imm[4:0]) : int'(b[4:0]);
            x   = lane_arith(a, b, amt, 32 >> insn.pw, insn.subclass);
        end
        default: r.ben = 4'h0;
    endcase
    r.data = x;
    return r;
endfunction

// Byte-enabled update of the shadow registers
task automatic model_commit(input cop_result_t r);
    for (int i = 0; i < 4; i++) begin
        if (r.ben[i]) ref_regs[r.rd][8*i +: 8] = r.data[8*i +: 8];
    end
endtask

`endif

// File: verification/cop_tb.sv
`timescale 1ns/100ps

module cop_tb;
    import cop_pkg::*;

    typedef struct {
        cop_result_t res;
        int          cyc;                 // Cycle of the issue strobe
    } pending_t;

    logic        g_clk;
    logic        arst_n;
    logic        issue_valid;
    cop_insn_t   issue;
    logic        result_valid;
    cop_result_t result;

    logic [31:0] seed;
    int          cycle;
    int          n_checks, n_errors;
    string       test_name;
    pending_t    exp_q [$];

    `include "cop_ref_model.svh"

    cop_top uut (
        .g_clk        (g_clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;        // 10 ns period
    end

    always @(posedge g_clk) cycle <= cycle + 1;

    // --------------------------------------------------
    // LCG with fixed seed
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic cop_insn_t make_insn(input logic [2:0] ic, input logic [3:0] sc,
                                            input logic [2:0] pw);
        cop_insn_t i;
        i.iclass   = ic;
        i.subclass = sc;
        i.pw       = pw;
        i.rd       = 4'(next_rand() >> 8);
        i.rs1      = 4'(next_rand() >> 8);
        i.rs2      = 4'(next_rand() >> 8);
        i.rs3      = 4'(next_rand() >> 8);
        i.imm      = next_rand();
        i.gpr_rs1  = next_rand();
        return i;
    endfunction

    // Drive one strobe and run the model in issue order
    task automatic issue_insn(input cop_insn_t insn);
        pending_t p;
        @(posedge g_clk);
        #1;
        p.res = model_exec(insn);
        p.cyc = cycle;
        model_commit(p.res);
        issue       = insn;
        issue_valid = 1'b1;
        exp_q.push_back(p);
    endtask

    task automatic move_to(input logic [3:0] rd, input logic [31:0] val);
        cop_insn_t i;
        i         = make_insn(cop_iclass_move, cop_sclass_mv2cop, cop_pw_32);
        i.rd      = rd;
        i.gpr_rs1 = val;
        issue_insn(i);
    endtask

    // Stop issuing and wait for all outstanding results
    task automatic finish_test(input int chk0, input int err0);
        int n;
        n = 0;
        @(posedge g_clk);
        #1;
        issue_valid = 1'b0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge g_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("Timeout in test %s with %0d results still outstanding", test_name,
                     exp_q.size());
            exp_q.delete();
        end
        $display("Test %s done: %0d checks, %0d errors", test_name,
                 n_checks - chk0, n_errors - err0);
    endtask

    // --------------------------------------------------
    // Result monitor sampled mid-cycle
    always @(negedge g_clk) begin : monitor
        pending_t got;
        if (arst_n) begin
            if (result_valid && exp_q.size() == 0) begin
                n_errors++;
                $display("Unexpected result for rd %0d in test %s", result.rd, test_name);
            end else if (result_valid) begin
                got      = exp_q.pop_front();
                n_checks += 4;
                if (result.rd !== got.res.rd) begin
                    n_errors++;
                    $display("ERROR %s rd expected %0d actual %0d", test_name,
                             got.res.rd, result.rd);
                end
                if (result.ben !== got.res.ben) begin
                    n_errors++;
                    $display("ERROR %s ben expected %h actual %h", test_name,
                             got.res.ben, result.ben);
                end
                if (result.data !== got.res.data) begin
                    n_errors++;
                    $display("ERROR %s data expected %h actual %h", test_name,
                             got.res.data, result.data);
                end
                if (cycle - got.cyc != 2) begin
                    n_errors++;
                    $display("ERROR %s latency expected 2 actual %0d", test_name,
                             cycle - got.cyc);
                end
            end
            if (exp_q.size() != 0 && cycle - exp_q[0].cyc > 4) begin
                n_errors++;
                $display("Missing result for rd %0d in test %s", exp_q[0].res.rd, test_name);
                void'(exp_q.pop_front());
            end
        end
    end

    // --------------------------------------------------
    initial begin : stimulus
        int        c0, e0, prev;
        cop_insn_t i;
        seed        = 32'h5852;
        cycle       = 0;
        n_checks    = 0;
        n_errors    = 0;
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        for (int r = 0; r < 16; r++) ref_regs[r] = '0;
        repeat (8) @(posedge g_clk);
        #1;
        arst_n = 1'b1;

        test_name = "reset_moves";
        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 5; k++) begin
            @(negedge g_clk);
            n_checks++;
            if (result_valid !== 1'b0) begin
                n_errors++;
                $display("ERROR %s result_valid expected 0 actual %b", test_name, result_valid);
            end
        end
        for (int r = 0; r < 16; r++) move_to(4'(r), next_rand());
        move_to(4'd15, 32'd0);            // Known zero for conditions
        for (int k = 0; k < 16; k++) begin
            i     = make_insn(cop_iclass_move, 4'(k % 2), cop_pw_32);
            i.rd  = 4'(next_rand() % 15);
            i.rs2 = (k % 4 < 2) ? 4'd15 : 4'(next_rand() % 15);
            issue_insn(i);
        end
        finish_test(c0, e0);

        test_name = "bitwise";
        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 35; k++) begin
            issue_insn(make_insn(cop_iclass_bitwise, 4'(next_rand() % 7), 0));
        end
        finish_test(c0, e0);

        test_name = "twiddle";
        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 35; k++) begin
            issue_insn(make_insn(cop_iclass_twiddle, 4'(next_rand() % 7), 0));
        end
        finish_test(c0, e0);

        test_name = "add_sub";
        c0 = n_checks;
        e0 = n_errors;
        move_to(4'd14, 32'hffff_ffff);    // All-ones lanes expose carry leaks
        for (int pw = 0; pw < 5; pw++) begin
            i     = make_insn(cop_iclass_parith, cop_sclass_add, 3'(pw));
            i.rs1 = 4'd14;
            i.rs2 = 4'd14;
            i.rd  = 4'(next_rand() % 14);
            issue_insn(i);
            for (int k = 0; k < 8; k++) begin
                i    = make_insn(cop_iclass_parith, 4'(next_rand() % 2), 3'(pw));
                i.rd = 4'(next_rand() % 14);
                issue_insn(i);
            end
        end
        finish_test(c0, e0);

        test_name = "shifts";
        c0 = n_checks;
        e0 = n_errors;
        for (int pw = 0; pw < 5; pw++) begin
            for (int sc = 2; sc < 8; sc++) begin
                repeat (3) issue_insn(make_insn(cop_iclass_parith, 4'(sc), 3'(pw)));
            end
        end
        finish_test(c0, e0);

        test_name = "back_to_back";
        c0 = n_checks;
        e0 = n_errors;
        prev = 0;
        for (int k = 0; k < 30; k++) begin
            case (next_rand() % 3)
                0: begin
                    i = make_insn(cop_iclass_parith, 4'(next_rand() % 8),
                                  3'(next_rand() % 5));
                end
                1: begin
                    i = make_insn(cop_iclass_bitwise, 4'(next_rand() % 7), 0);
                end
                default: begin
                    i = make_insn(cop_iclass_twiddle, 4'(next_rand() % 7), 0);
                end
            endcase
            i.rs1 = 4'(prev);             // Reads the previous rd
            i.rs3 = 4'(prev);
            prev  = int'(i.rd);
            issue_insn(i);
        end
        finish_test(c0, e0);

        $display("Total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
